// File: run_sim.sh
#!/usr/bin/env bash
# Builds the TL-UL SRAM testbench with Verilator and runs it.
# The exit status is nonzero when the build or the simulation fails.
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f sim.f --top-module tb_tlul_sram -o tb_tlul_sram \
  && ./obj_dir/tb_tlul_sram \
  || { echo "run_sim.sh: build or simulation failed"; exit 1; }

// File: sim.f
+incdir+.
tlul_pkg.sv
sram_pkg.sv
tlul_rsp_fifo.sv
tlul_sram_req_adapter.sv
tlul_rsp_builder.sv
sram_model.sv
tlul_sram_top.sv
tlul_sram_checker.sv
tb_tlul_sram.sv

// File: sram_model.sv
/*
 * Single-port word SRAM with a bit write mask and one-cycle read latency.
 * Every write costs one extra cycle of recovery with gnt low.
 */
`timescale 1ns/1ps
`include "tlul_sram_settings.svh"

module sram_model (
  input  logic                clk_i,
  input  logic                rst_i,
  input  sram_pkg::sram_req_t sram_req_i,
  output logic                gnt_o,
  output logic                rvalid_o,
  output logic [`TL_DW-1:0]   rdata_o
);

  localparam int WORDS = 1 << `SRAM_AW;

  logic [`TL_DW-1:0] mem_q [WORDS];
  logic [`TL_DW-1:0] rdata_q;
  logic              busy_q;
  logic              rvalid_q;
  logic              take;

  assign gnt_o = !busy_q;
  assign take  = sram_req_i.req && gnt_o;

  // Array and read register
  always_ff @(posedge clk_i) begin
    if (take && sram_req_i.we) begin
      mem_q[sram_req_i.addr] <= (mem_q[sram_req_i.addr] & ~sram_req_i.wmask) |
                                (sram_req_i.wdata & sram_req_i.wmask);
    end
    if (take && !sram_req_i.we) begin
      rdata_q <= mem_q[sram_req_i.addr];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q   <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      busy_q   <= take && sram_req_i.we;
      rvalid_q <= take && !sram_req_i.we;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: sram_pkg.sv
/*
 * Types on the memory side of the port: the SRAM request and the
 * descriptor that records how each accepted request must be answered.
 */
`include "tlul_sram_settings.svh"

package sram_pkg;

  // One SRAM access, the mask is already expanded to one bit per data bit
  typedef struct packed {
    logic                  req;
    logic                  we;
    logic [`SRAM_AW-1:0]   addr;
    logic [`TL_DW-1:0]     wdata;
    logic [`TL_DW-1:0]     wmask;
  } sram_req_t;

  // Pending response, has_data tells the builder to wait for read data
  typedef struct packed {
    tlul_pkg::tl_d_op_e    opcode;
    logic [1:0]            size;
    logic [`TL_SRCW-1:0]   source;
    logic                  error;
    logic                  has_data;
  } rsp_desc_t;

endpackage

// File: tb_tlul_sram.sv
/*
 * Testbench for tlul_sram_top. Directed and random TL-UL traffic is checked
 * beat by beat against a shadow memory. Build it with sim.f.
 */
`timescale 1ns/1ps
`include "tlul_sram_settings.svh"

module tb_tlul_sram;

  localparam int WORDS      = 1 << `SRAM_AW;
  localparam int HI_W       = `TL_AW - `SRAM_AW - 2;
  localparam int RAND_TXN   = 320;
  localparam int MAX_CYCLES = 400 * 10;

  logic            clk_i = 1'b0;
  logic            rst_i;
  tlul_pkg::tl_a_t tl_a_i;
  logic            tl_a_ready_o;
  tlul_pkg::tl_d_t tl_d_o;
  logic            tl_d_ready_i = 1'b1;

  logic [`TL_DW-1:0] shadow [WORDS];
  tlul_pkg::tl_d_t   exp_q [$];
  int                cycle_cnt = 0;
  logic              rand_ready;

  tlul_sram_top uut (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .tl_a_i       (tl_a_i),
    .tl_a_ready_o (tl_a_ready_o),
    .tl_d_o       (tl_d_o),
    .tl_d_ready_i (tl_d_ready_i)
  );

  always #20 clk_i = ~clk_i;

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic check_d_beat(input tlul_pkg::tl_d_t got, input tlul_pkg::tl_d_t exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch tl_d_o: got %h, expected %h (source %h, data %h vs %h)",
                         got, exp, exp.source, got.data, exp.data));
    end
  endtask

  task automatic check_ready(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("Mismatch %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // Each word of the random window gets a value built from its whole index
  function automatic logic [`TL_DW-1:0] fill_word(input int unsigned idx);
    logic [9:0] w;
    w = 10'(idx);
    return {6'h2a, w, 6'h15, w};
  endfunction

  function automatic tlul_pkg::tl_a_t make_req(input logic [2:0] op, input logic [31:0] addr,
                                               input logic [1:0] size, input logic [3:0] mask,
                                               input logic [31:0] data, input logic [5:0] src);
    tlul_pkg::tl_a_t a;
    a         = '0;
    a.valid   = 1'b1;
    a.opcode  = tlul_pkg::tl_a_op_e'(op);
    a.size    = size;
    a.source  = src;
    a.address = addr;
    a.mask    = mask;
    a.data    = data;
    return a;
  endfunction

  // Mostly legal traffic inside words 0 to 15 with one request in ten broken
  function automatic tlul_pkg::tl_a_t rand_req();
    logic [1:0]  sz;
    logic [1:0]  off;
    logic [2:0]  op;
    int unsigned kind;
    sz   = 2'($urandom_range(0, 2));
    off  = (sz == 2'd2) ? 2'd0 : ((sz == 2'd1) ? {1'($urandom()), 1'b0} : 2'($urandom()));
    kind = $urandom_range(0, 9);
    if (kind < 4) begin
      op = 3'd4;
    end else if (kind < 6) begin
      op = 3'd0;
    end else begin
      op = ($urandom_range(0, 1) != 0) ? 3'd1 : 3'd4;
    end
    rand_req = make_req(op, {26'd0, 4'($urandom()), off}, sz, 4'($urandom()),
                        `TL_DW'($urandom()), `TL_SRCW'($urandom()));
    if (kind == 9) begin
      case ($urandom_range(0, 3))
        0: rand_req.opcode = tlul_pkg::tl_a_op_e'(3'd2 + 3'($urandom_range(0, 1)));
        1: begin
          rand_req.size          = 2'd2;
          rand_req.address[1:0]  = 2'($urandom_range(1, 3));
        end
        2: rand_req.size = 2'd3;
        default: rand_req.address[`TL_AW-1:`SRAM_AW+2] = HI_W'($urandom_range(1, 1000));
      endcase
    end
  endfunction

  // Expected D beat for an accepted request and the write it makes to the shadow memory
  function automatic tlul_pkg::tl_d_t expect_d(input tlul_pkg::tl_a_t a);
    tlul_pkg::tl_d_t   d;
    logic              bad;
    logic              full;
    logic [`SRAM_AW-1:0] widx;
    full = (a.opcode == tlul_pkg::PutFullData);
    bad  = !(full || a.opcode == tlul_pkg::PutPartialData || a.opcode == tlul_pkg::Get);
    bad  = bad || (a.size == 2'd3) || (a.address >= 32'(4 * WORDS));
    bad  = bad || (a.size == 2'd1 && a.address[0]) || (a.size == 2'd2 && a.address[1:0] != 0);
    widx = a.address[`SRAM_AW+1:2];
    d        = '0;
    d.valid  = 1'b1;
    d.opcode = (a.opcode == tlul_pkg::Get) ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
    d.size   = a.size;
    d.source = a.source;
    d.error  = bad;
    if (!bad && a.opcode == tlul_pkg::Get) begin
      d.data = shadow[widx];
    end else if (!bad) begin
      for (int b = 0; b < 4; b++) begin
        if (full || a.mask[b]) begin
          shadow[widx][8*b +: 8] = a.data[8*b +: 8];
        end
      end
    end
    return d;
  endfunction

  // Called just after a rising edge and returns just after the transfer edge
  task automatic send_req(input tlul_pkg::tl_a_t a);
    tl_a_i <= a;
    @(negedge clk_i);
    while (!tl_a_ready_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    tl_a_i.valid <= 1'b0;
  endtask

  always @(posedge clk_i) begin
    tl_d_ready_i <= rand_ready ? ($urandom_range(0, 3) != 0) : 1'b1;
  end

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  // Handshakes are decided at the falling edge and transfer on the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i) begin
      if (tl_d_o.valid && tl_d_ready_i) begin
        if (exp_q.size() == 0) begin
          fail_run("A D-channel response appeared with no request outstanding");
        end else begin
          check_d_beat(tl_d_o, exp_q.pop_front());
        end
      end
      if (tl_a_i.valid && tl_a_ready_o) begin
        exp_q.push_back(expect_d(tl_a_i));
      end
    end
  end

  initial begin
    void'($urandom(32'h339f));
    rst_i      = 1'b1;
    tl_a_i     = '0;
    rand_ready = 1'b0;
    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    repeat (4) begin
      @(negedge clk_i);
      check_ready("tl_d_o.valid", tl_d_o.valid, 1'b0);
      check_ready("tl_a_ready_o", tl_a_ready_o, 1'b1);
    end
    @(posedge clk_i);
    for (int i = 0; i < 16; i++) begin
      send_req(make_req(3'd0, 32'(i * 4), 2'd2, 4'hf, fill_word(i), 6'(i)));
    end
    // Full write then read back and a byte read of the same word
    send_req(make_req(3'd0, 32'h0c, 2'd2, 4'hf, 32'hdead_beef, 6'h11));
    send_req(make_req(3'd4, 32'h0c, 2'd2, 4'hf, '0, 6'h12));
    send_req(make_req(3'd4, 32'h0d, 2'd0, 4'h2, '0, 6'h13));
    for (int i = 0; i < 6; i++) begin
      send_req(make_req(3'd1, 32'h14, 2'd2, 4'($urandom()), `TL_DW'($urandom()), 6'(32 + i)));
      send_req(make_req(3'd4, 32'h14, 2'd2, 4'hf, '0, 6'(48 + i)));
    end
    // Broken requests aimed at word 7, which must keep its contents
    send_req(make_req(3'd5, 32'h1c, 2'd2, 4'hf, 32'hffff_ffff, 6'h01));
    send_req(make_req(3'd0, 32'h1e, 2'd2, 4'hf, 32'hffff_ffff, 6'h02));
    send_req(make_req(3'd1, 32'h1d, 2'd1, 4'hf, 32'hffff_ffff, 6'h03));
    send_req(make_req(3'd0, 32'h1c, 2'd3, 4'hf, 32'hffff_ffff, 6'h04));
    send_req(make_req(3'd0, 32'(4 * WORDS) + 32'h1c, 2'd2, 4'hf, 32'hffff_ffff, 6'h05));
    send_req(make_req(3'd4, 32'(4 * WORDS), 2'd2, 4'hf, '0, 6'h06));
    send_req(make_req(3'd4, 32'h1c, 2'd2, 4'hf, '0, 6'h07));
    rand_ready <= 1'b1;
    for (int n = 0; n < RAND_TXN; n++) begin
      repeat ($urandom_range(0, 2)) @(posedge clk_i);
      send_req(rand_req());
    end
    rand_ready <= 1'b0;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
    end
    repeat (5) @(posedge clk_i);
    // With both FIFOs drained and no write pending the port takes requests again
    @(negedge clk_i);
    check_ready("tl_a_ready_o", tl_a_ready_o, 1'b1);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: tlul_pkg.sv
/*
 * TL-UL channel types for the single-beat device port.
 * Modules refer to these by scoped name, e.g. tlul_pkg::tl_a_t.
 */
`include "tlul_sram_settings.svh"

package tlul_pkg;

  // A-channel opcodes the port can see, anything else is rejected
  typedef enum logic [2:0] {
    PutFullData    = 3'd0,
    PutPartialData = 3'd1,
    Get            = 3'd4
  } tl_a_op_e;

  typedef enum logic [2:0] {
    AccessAck     = 3'd0,
    AccessAckData = 3'd1
  } tl_d_op_e;

  // Request beat from the host, size is log2 of the byte count
  typedef struct packed {
    logic                  valid;
    tl_a_op_e              opcode;
    logic [1:0]            size;
    logic [`TL_SRCW-1:0]   source;
    logic [`TL_AW-1:0]     address;
    logic [`TL_DW/8-1:0]   mask;
    logic [`TL_DW-1:0]     data;
  } tl_a_t;

  // Response beat back to the host
  typedef struct packed {
    logic                  valid;
    tl_d_op_e              opcode;
    logic [1:0]            size;
    logic [`TL_SRCW-1:0]   source;
    logic [`TL_DW-1:0]     data;
    logic                  error;
  } tl_d_t;

endpackage

// File: tlul_rsp_builder.sv
/*
 * D-channel back end: joins the descriptor at the FIFO head with its read
 * data and holds the beat until the host takes it.
 */
`timescale 1ns/1ps
`include "tlul_sram_settings.svh"

module tlul_rsp_builder (
  input  logic                clk_i,
  input  logic                rst_i,
  input  sram_pkg::rsp_desc_t desc_i,
  input  logic                desc_empty_i,
  input  logic [`TL_DW-1:0]   rdata_i,
  input  logic                data_empty_i,
  output tlul_pkg::tl_d_t     tl_d_o,
  input  logic                tl_d_ready_i,
  output logic                desc_pop_o,
  output logic                data_pop_o
);

  logic head_ready;
  logic held_q;

  // A read response waits until its data has landed in the data FIFO
  assign head_ready = !desc_empty_i && (!desc_i.has_data || !data_empty_i);

  // Set while an offered beat is stalled by the host
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_q <= 1'b0;
    end else begin
      held_q <= tl_d_o.valid && !tl_d_ready_i;
    end
  end

  // Both FIFO heads stay put until the pop, so the payload is stable
  // for as long as the beat is held
  always_comb begin
    tl_d_o.valid  = head_ready || held_q;
    tl_d_o.opcode = desc_i.opcode;
    tl_d_o.size   = desc_i.size;
    tl_d_o.source = desc_i.source;
    tl_d_o.data   = desc_i.has_data ? rdata_i : '0;
    tl_d_o.error  = desc_i.error;
  end

  assign desc_pop_o = tl_d_o.valid && tl_d_ready_i;
  assign data_pop_o = desc_pop_o && desc_i.has_data;

endmodule

// File: tlul_rsp_fifo.sv
/*
 * Synchronous FIFO of `RSP_DEPTH entries for in-flight responses.
 * Used once for descriptors and once for SRAM read data.
 */
`timescale 1ns/1ps
`include "tlul_sram_settings.svh"

module tlul_rsp_fifo #(
  parameter int WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic             pop_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             empty_o,
  output logic             full_o
);

  localparam int DEPTH = `RSP_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Head is read straight from the array, so a push shows one cycle later
  assign rdata_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: tlul_sram_checker.sv
/*
 * Handshake assertions for the TL-UL port, bound into tlul_sram_top.
 */
`timescale 1ns/1ps

module tlul_sram_checker (
  input logic            clk_i,
  input logic            rst_i,
  input tlul_pkg::tl_a_t tl_a_i,
  input logic            tl_a_ready_o,
  input tlul_pkg::tl_d_t tl_d_o,
  input logic            tl_d_ready_i
);

  logic [15:0] a_cnt_q;
  logic [15:0] d_cnt_q;

  // Beats that have crossed each channel since reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_cnt_q <= '0;
      d_cnt_q <= '0;
    end else begin
      if (tl_a_i.valid && tl_a_ready_o) begin
        a_cnt_q <= a_cnt_q + 16'd1;
      end
      if (tl_d_o.valid && tl_d_ready_i) begin
        d_cnt_q <= d_cnt_q + 16'd1;
      end
    end
  end

  // A stalled response keeps valid and its whole payload
  d_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    (tl_d_o.valid && !tl_d_ready_i) |=> (tl_d_o.valid && $stable(tl_d_o)))
    else $error("D channel changed while stalled by the host");

  reset_quiet: assert property (@(posedge clk_i)
    $fell(rst_i) |-> (!tl_a_ready_o && !tl_d_o.valid))
    else $error("Port active in the first cycle after reset");

  d_after_a: assert property (@(posedge clk_i) disable iff (rst_i)
    (tl_d_o.valid && tl_d_ready_i) |-> (d_cnt_q < a_cnt_q))
    else $error("More D beats than accepted A beats");

endmodule

bind tlul_sram_top tlul_sram_checker u_checker (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .tl_a_i       (tl_a_i),
  .tl_a_ready_o (tl_a_ready_o),
  .tl_d_o       (tl_d_o),
  .tl_d_ready_i (tl_d_ready_i)
);

// File: tlul_sram_req_adapter.sv
/*
 * A-channel front end: checks each request, issues the SRAM access in the
 * acceptance cycle and pushes a descriptor for the matching response.
 */
`timescale 1ns/1ps
`include "tlul_sram_settings.svh"

module tlul_sram_req_adapter (
  input  logic                clk_i,
  input  logic                rst_i,
  input  tlul_pkg::tl_a_t     tl_a_i,
  output logic                tl_a_ready_o,
  input  logic                gnt_i,
  output sram_pkg::sram_req_t sram_req_o,
  input  logic                desc_full_i,
  output logic                desc_push_o,
  output sram_pkg::rsp_desc_t desc_o
);

  logic              en_q;
  logic              is_get;
  logic              is_full;
  logic              op_ok;
  logic              size_ok;
  logic              align_ok;
  logic              range_ok;
  logic              req_err;
  logic              accept;
  logic [`TL_DW-1:0] bit_mask;

  // The port opens one cycle after reset is released
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      en_q <= 1'b0;
    end else begin
      en_q <= 1'b1;
    end
  end

  assign is_get  = (tl_a_i.opcode == tlul_pkg::Get);
  assign is_full = (tl_a_i.opcode == tlul_pkg::PutFullData);
  assign op_ok   = is_get || is_full || (tl_a_i.opcode == tlul_pkg::PutPartialData);

  // Only single-beat accesses up to one 32-bit word are supported
  assign size_ok = (tl_a_i.size != 2'd3);

  always_comb begin
    case (tl_a_i.size)
      2'd1:    align_ok = !tl_a_i.address[0];
      2'd2:    align_ok = (tl_a_i.address[1:0] == 2'b00);
      default: align_ok = 1'b1;
    endcase
  end

  // Any address bit above the SRAM word range makes the request fail
  assign range_ok = (tl_a_i.address[`TL_AW-1:`SRAM_AW+2] == '0);

  assign req_err = tl_a_i.valid && !(op_ok && size_ok && align_ok && range_ok);

  // A failing request never reaches the SRAM, so it does not wait for gnt
  assign tl_a_ready_o = en_q && !desc_full_i && (req_err || gnt_i);
  assign accept       = tl_a_i.valid && tl_a_ready_o;

  always_comb begin
    for (int b = 0; b < `TL_DW / 8; b++) begin
      bit_mask[8*b +: 8] = {8{is_full || tl_a_i.mask[b]}};
    end
  end

  always_comb begin
    sram_req_o.req   = accept && !req_err;
    sram_req_o.we    = !is_get;
    sram_req_o.addr  = tl_a_i.address[`SRAM_AW+1:2];
    sram_req_o.wdata = tl_a_i.data;
    sram_req_o.wmask = bit_mask;
  end

  // A Get is answered with AccessAckData even when it fails
  always_comb begin
    desc_o.opcode   = is_get ? tlul_pkg::AccessAckData : tlul_pkg::AccessAck;
    desc_o.size     = tl_a_i.size;
    desc_o.source   = tl_a_i.source;
    desc_o.error    = req_err;
    desc_o.has_data = is_get && !req_err;
  end

  assign desc_push_o = accept;

endmodule

// File: tlul_sram_settings.svh
/*
 * Bus widths and sizing for the TL-UL SRAM subsystem.
 * Included by the packages and by every module that sizes a port or an array.
 */
`ifndef TLUL_SRAM_SETTINGS_SVH
`define TLUL_SRAM_SETTINGS_SVH

// TL-UL address, data and source widths
`define TL_AW 32
`define TL_DW 32
`define TL_SRCW 6

// Word address width of the SRAM, 1024 words of 32 bits
`define SRAM_AW 10

// Responses that may be in flight between the A and D channels
`define RSP_DEPTH 4

`endif

// File: tlul_sram_top.sv
/*
 * TL-UL device port in front of a 1024-word SRAM.
 * Requests enter on tl_a_i and responses leave in order on tl_d_o.
 */
`timescale 1ns/1ps
`include "tlul_sram_settings.svh"

module tlul_sram_top (
  input  logic            clk_i,
  input  logic            rst_i,
  input  tlul_pkg::tl_a_t tl_a_i,
  output logic            tl_a_ready_o,
  output tlul_pkg::tl_d_t tl_d_o,
  input  logic            tl_d_ready_i
);

  sram_pkg::sram_req_t sram_req;
  sram_pkg::rsp_desc_t desc_in;
  sram_pkg::rsp_desc_t desc_head;
  logic                gnt;
  logic                rvalid;
  logic [`TL_DW-1:0]   rdata;
  logic [`TL_DW-1:0]   data_head;
  logic                desc_push;
  logic                desc_pop;
  logic                desc_empty;
  logic                desc_full;
  logic                data_pop;
  logic                data_empty;

  tlul_sram_req_adapter u_adapter (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .tl_a_i       (tl_a_i),
    .tl_a_ready_o (tl_a_ready_o),
    .gnt_i        (gnt),
    .sram_req_o   (sram_req),
    .desc_full_i  (desc_full),
    .desc_push_o  (desc_push),
    .desc_o       (desc_in)
  );

  tlul_rsp_fifo #(.WIDTH($bits(sram_pkg::rsp_desc_t))) u_desc_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (desc_push),
    .wdata_i (desc_in),
    .pop_i   (desc_pop),
    .rdata_o (desc_head),
    .empty_o (desc_empty),
    .full_o  (desc_full)
  );

  // Never holds more entries than the descriptor FIFO so its full flag stays open
  tlul_rsp_fifo #(.WIDTH(`TL_DW)) u_data_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .push_i  (rvalid),
    .wdata_i (rdata),
    .pop_i   (data_pop),
    .rdata_o (data_head),
    .empty_o (data_empty),
    .full_o  ()
  );

  tlul_rsp_builder u_builder (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .desc_i       (desc_head),
    .desc_empty_i (desc_empty),
    .rdata_i      (data_head),
    .data_empty_i (data_empty),
    .tl_d_o       (tl_d_o),
    .tl_d_ready_i (tl_d_ready_i),
    .desc_pop_o   (desc_pop),
    .data_pop_o   (data_pop)
  );

  sram_model u_sram (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .sram_req_i (sram_req),
    .gnt_o      (gnt),
    .rvalid_o   (rvalid),
    .rdata_o    (rdata)
  );

endmodule
